/* design/pwo_pkg.sv */
// Modulus is fixed to q = 2^23 - 2^13 + 1 and addresses are limited to 8 bits
package pwo_pkg;

    localparam int coef_width     = 24;
    localparam int lanes          = 4;
    localparam int word_width     = coef_width * lanes;
    localparam int addr_max_width = 8;   // Modules keep only their low address bits

    // Dilithium prime
    localparam logic [coef_width-1:0] coef_q = 24'd8380417;

    typedef enum logic [1:0] {
        pwm = 2'd0,   // Multiply, optional accumulate into C
        pwa = 2'd1,
        pws = 2'd2
    } pwo_mode_e;

    // Target of a host write
    typedef enum logic [1:0] {
        mem_a = 2'd0,
        mem_b = 2'd1,
        mem_c = 2'd2
    } mem_sel_e;

    typedef struct packed {
        logic                      en;
        logic [addr_max_width-1:0] addr;
        logic [word_width-1:0]     data;
    } mem_wr_t;

    typedef struct packed {
        mem_wr_t  wr;
        mem_sel_e sel;
    } host_wr_t;

endpackage

/* design/coef_ram.sv */
// Depth is coef_count/4 words; read data holds its last value while rd_en_i is low
`timescale 1ns/1ps

module coef_ram #(
    parameter int coef_count = 256,
    parameter int addr_width = 6
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           zeroize_i,
    input  pwo_pkg::mem_wr_t               wr_i,
    input  logic                           rd_en_i,
    input  logic [addr_width-1:0]          rd_addr_i,
    output logic [pwo_pkg::word_width-1:0] rd_data_o
);

    import pwo_pkg::*;

    localparam int depth = coef_count / lanes;

    logic [word_width-1:0] mem [depth];
    logic [addr_width-1:0] wr_addr;

    assign wr_addr = wr_i.addr[addr_width-1:0];   // Low bits of the shared address field

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
            rd_data_o <= '0;
        end else if (zeroize_i) begin
            // Wipe every word in a single cycle
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
            rd_data_o <= '0;
        end else begin
            if (wr_i.en) begin
                mem[wr_addr] <= wr_i.data;
            end
            if (rd_en_i) begin
                rd_data_o <= mem[rd_addr_i];   // Old data on a same-address write
            end
        end
    end

endmodule

/* design/mod_arith_lane.sv */
// Operands must be below q; the fold chain relies on q = 2^23 - 2^13 + 1
`timescale 1ns/1ps

module mod_arith_lane (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           valid_i,
    input  pwo_pkg::pwo_mode_e             mode_i,
    input  logic                           accumulate_i,
    input  logic [pwo_pkg::coef_width-1:0] a_i,
    input  logic [pwo_pkg::coef_width-1:0] b_i,
    input  logic [pwo_pkg::coef_width-1:0] c_i,
    output logic                           valid_o,
    output logic [pwo_pkg::coef_width-1:0] result_o
);

    import pwo_pkg::*;

    localparam int prod_width = 2 * coef_width - 2;   // 46 bits, operands below 2^23

    logic [prod_width-1:0] prod;

    logic                  st1_valid;
    pwo_mode_e             st1_mode;
    logic                  st1_acc;
    logic                  st1_neg;
    logic [prod_width-1:0] st1_val;
    logic [coef_width-1:0] st1_c;

    logic                  st2_valid;
    pwo_mode_e             st2_mode;
    logic                  st2_acc;
    logic                  st2_neg;
    logic [coef_width-1:0] st2_val;
    logic [coef_width-1:0] st2_c;

    // Fold chain, each step uses 2^23 = 2^13 - 1 mod q
    logic [22:0]           f1_hi;
    logic [22:0]           f1_lo;
    logic [36:0]           f1;
    logic [13:0]           f2_hi;
    logic [22:0]           f2_lo;
    logic [27:0]           f2;
    logic [4:0]            f3_hi;
    logic [22:0]           f3_lo;
    logic [24:0]           f3;
    logic [coef_width-1:0] red;

    logic [coef_width:0]   acc_sum;
    logic [coef_width-1:0] fin;

    assign prod = a_i[22:0] * b_i[22:0];

    assign f1_hi = st1_val[45:23];
    assign f1_lo = st1_val[22:0];
    assign f1    = {f1_hi, 13'd0} - f1_hi + f1_lo;
    assign f2_hi = f1[36:23];
    assign f2_lo = f1[22:0];
    assign f2    = {f2_hi, 13'd0} - f2_hi + f2_lo;
    assign f3_hi = f2[27:23];
    assign f3_lo = f2[22:0];
    assign f3    = {f3_hi, 13'd0} - f3_hi + f3_lo;   // Now below 2q

    assign red = (f3 >= 25'(coef_q)) ? coef_width'(f3 - 25'(coef_q)) : f3[coef_width-1:0];

    // Final correction
    always_comb begin
        acc_sum = {1'b0, st2_val};
        if (st2_mode == pwm && st2_acc) begin
            acc_sum = st2_val + st2_c;
        end
        if (st2_mode == pws) begin
            fin = st2_neg ? st2_val + coef_q : st2_val;   // Wraps back into range
        end else if (acc_sum >= {1'b0, coef_q}) begin
            fin = coef_width'(acc_sum - {1'b0, coef_q});
        end else begin
            fin = acc_sum[coef_width-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            st1_valid <= 1'b0;
            st2_valid <= 1'b0;
            valid_o   <= 1'b0;
        end else begin
            st1_valid <= valid_i;
            st2_valid <= st1_valid;
            valid_o   <= st2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            st1_mode <= mode_i;
            st1_acc  <= accumulate_i;
            st1_c    <= c_i;
            st1_neg  <= (mode_i == pws) && (a_i < b_i);
            case (mode_i)
                pwm:     st1_val <= prod;
                pwa:     st1_val <= a_i + b_i;
                default: st1_val <= prod_width'(a_i - b_i);   // Raw difference mod 2^24
            endcase
        end
        if (st1_valid) begin
            st2_mode <= st1_mode;
            st2_acc  <= st1_acc;
            st2_c    <= st1_c;
            st2_neg  <= st1_neg;
            st2_val  <= (st1_mode == pwm) ? red : st1_val[coef_width-1:0];
        end
        if (st2_valid) begin
            result_o <= fin;
        end
    end

endmodule

/* design/pwo_ctrl.sv */
// Assumes coef_count/4 fits addr_width; start_i is ignored while busy_o is high
`timescale 1ns/1ps

module pwo_ctrl #(
    parameter int coef_count = 256,
    parameter int addr_width = 6
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  start_i,
    input  pwo_pkg::pwo_mode_e    mode_i,
    input  logic                  accumulate_i,
    output logic                  rd_en_o,
    output logic [addr_width-1:0] rd_addr_o,
    output logic                  lane_valid_o,
    output pwo_pkg::pwo_mode_e    lane_mode_o,
    output logic                  lane_acc_o,
    input  logic                  lane_valid_i,
    output pwo_pkg::mem_wr_t      c_wr_o,
    output logic                  busy_o,
    output logic                  done_o
);

    import pwo_pkg::*;

    localparam int words      = coef_count / lanes;
    localparam int pipe_depth = 4;   // Memory read plus three lane stages

    localparam logic [addr_width-1:0] last_addr = addr_width'(words - 1);

    logic                  rd_last;
    logic                  wr_last;
    logic [addr_width-1:0] addr_sh [pipe_depth];
    logic [pipe_depth-1:0] last_sh;

    assign rd_last = rd_en_o && (rd_addr_o == last_addr);
    assign wr_last = lane_valid_i && last_sh[pipe_depth-1];

    // Sequencer
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_o       <= 1'b0;
            done_o       <= 1'b0;
            rd_en_o      <= 1'b0;
            rd_addr_o    <= '0;
            lane_valid_o <= 1'b0;
            lane_mode_o  <= pwm;
            lane_acc_o   <= 1'b0;
        end else begin
            done_o       <= wr_last;   // One cycle after the final C write
            lane_valid_o <= rd_en_o;   // Read data lands one cycle later
            if (start_i && !busy_o) begin
                busy_o      <= 1'b1;
                rd_en_o     <= 1'b1;
                rd_addr_o   <= '0;
                lane_mode_o <= mode_i;
                lane_acc_o  <= accumulate_i;
            end else begin
                if (rd_en_o) begin
                    if (rd_last) begin
                        rd_en_o <= 1'b0;
                    end else begin
                        rd_addr_o <= rd_addr_o + 1'b1;
                    end
                end
                if (wr_last) begin
                    busy_o <= 1'b0;
                end
            end
        end
    end

    // Address shift tracking the data through the pipeline
    always_ff @(posedge clk) begin
        addr_sh[0] <= rd_addr_o;
        for (int i = 1; i < pipe_depth; i++) begin
            addr_sh[i] <= addr_sh[i-1];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_sh <= '0;
        end else begin
            last_sh <= {last_sh[pipe_depth-2:0], rd_last};   // Marks the final word
        end
    end

    // Data field is filled by the top level from the lanes
    assign c_wr_o = '{
        en:   lane_valid_i,
        addr: addr_max_width'(addr_sh[pipe_depth-1]),
        data: '0
    };

endmodule

/* design/pwo_top.sv */
// Host access is legal only while busy_o is low; the engine owns every memory while busy
`timescale 1ns/1ps

module pwo_top #(
    parameter int coef_count = 256,
    parameter int addr_width = $clog2(coef_count / 4)
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           zeroize_i,
    input  logic                           start_i,
    input  pwo_pkg::pwo_mode_e             mode_i,
    input  logic                           accumulate_i,
    input  pwo_pkg::host_wr_t              host_wr_i,
    input  logic                           host_rd_en_i,
    input  logic [addr_width-1:0]          host_rd_addr_i,
    output logic [pwo_pkg::word_width-1:0] host_rd_data_o,
    output logic                           busy_o,
    output logic                           done_o
);

    import pwo_pkg::*;

    logic                  eng_rd_en;
    logic [addr_width-1:0] eng_rd_addr;
    logic                  lane_valid_in;
    logic                  lane_valid_in_ctrl;   // Lane operand valid from the sequencer
    pwo_mode_e             lane_mode;
    logic                  lane_acc;
    logic [lanes-1:0]      lane_valid_out;
    logic [word_width-1:0] a_rd_data;
    logic [word_width-1:0] b_rd_data;
    logic [word_width-1:0] c_rd_data;
    logic [word_width-1:0] lane_result;
    mem_wr_t               eng_c_wr;
    mem_wr_t               a_wr;
    mem_wr_t               b_wr;
    mem_wr_t               c_wr;
    logic                  c_rd_en;
    logic [addr_width-1:0] c_rd_addr;
    logic                  host_wr_ok;

    assign host_wr_ok = host_wr_i.wr.en && !busy_o;   // Host writes dropped while busy

    always_comb begin
        a_wr    = host_wr_i.wr;
        a_wr.en = host_wr_ok && (host_wr_i.sel == mem_a);
        b_wr    = host_wr_i.wr;
        b_wr.en = host_wr_ok && (host_wr_i.sel == mem_b);
        if (busy_o) begin
            c_wr      = eng_c_wr;
            c_wr.data = lane_result;
        end else begin
            c_wr    = host_wr_i.wr;
            c_wr.en = host_wr_ok && (host_wr_i.sel == mem_c);
        end
    end

    // C read port is shared with the host
    assign c_rd_en        = busy_o ? eng_rd_en : host_rd_en_i;
    assign c_rd_addr      = busy_o ? eng_rd_addr : host_rd_addr_i;
    assign host_rd_data_o = c_rd_data;
    assign lane_valid_in  = lane_valid_out[0];

    coef_ram #(.coef_count(coef_count), .addr_width(addr_width)) a_ram (
        .clk(clk), .rst_n_i(rst_n_i), .zeroize_i(zeroize_i), .wr_i(a_wr),
        .rd_en_i(eng_rd_en), .rd_addr_i(eng_rd_addr), .rd_data_o(a_rd_data)
    );

    coef_ram #(.coef_count(coef_count), .addr_width(addr_width)) b_ram (
        .clk(clk), .rst_n_i(rst_n_i), .zeroize_i(zeroize_i), .wr_i(b_wr),
        .rd_en_i(eng_rd_en), .rd_addr_i(eng_rd_addr), .rd_data_o(b_rd_data)
    );

    coef_ram #(.coef_count(coef_count), .addr_width(addr_width)) c_ram (
        .clk(clk), .rst_n_i(rst_n_i), .zeroize_i(zeroize_i), .wr_i(c_wr),
        .rd_en_i(c_rd_en), .rd_addr_i(c_rd_addr), .rd_data_o(c_rd_data)
    );

    pwo_ctrl #(.coef_count(coef_count), .addr_width(addr_width)) i_ctrl (
        .clk(clk), .rst_n_i(rst_n_i), .start_i(start_i), .mode_i(mode_i),
        .accumulate_i(accumulate_i), .rd_en_o(eng_rd_en), .rd_addr_o(eng_rd_addr),
        .lane_valid_o(lane_valid_in_ctrl), .lane_mode_o(lane_mode), .lane_acc_o(lane_acc),
        .lane_valid_i(lane_valid_in), .c_wr_o(eng_c_wr), .busy_o(busy_o), .done_o(done_o)
    );

    // One lane per coefficient slot of a word
    for (genvar g = 0; g < lanes; g++) begin : g_lane
        mod_arith_lane i_lane (
            .clk(clk), .rst_n_i(rst_n_i), .valid_i(lane_valid_in_ctrl),
            .mode_i(lane_mode), .accumulate_i(lane_acc),
            .a_i(a_rd_data[g*coef_width +: coef_width]),
            .b_i(b_rd_data[g*coef_width +: coef_width]),
            .c_i(c_rd_data[g*coef_width +: coef_width]),
            .valid_o(lane_valid_out[g]),
            .result_o(lane_result[g*coef_width +: coef_width])
        );
    end

endmodule

/* tb/pwo_assertions.sv */
// Single clock domain assumed; properties are idle while rst_n_i is low
`timescale 1ns/1ps

module pwo_assertions (
    input logic              clk,
    input logic              rst_n_i,
    input logic              busy_i,
    input logic              done_i,
    input pwo_pkg::host_wr_t host_wr_i
);

    int fail_count = 0;   // Read by the testbench summary

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        done_i |=> !done_i)
        else begin
            fail_count++;
            $error("done_o stayed high for more than one cycle");
        end

    // Busy ends in the same cycle as the done pulse
    a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n_i)
        $fell(busy_i) |-> done_i)
        else begin
            fail_count++;
            $error("busy_o fell without done_o");
        end

    a_done_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        done_i |-> !busy_i)
        else begin
            fail_count++;
            $error("busy_o still high during done_o");
        end

    a_no_host_wr: assert property (@(posedge clk) disable iff (!rst_n_i)
        busy_i |-> !host_wr_i.wr.en)   // Engine owns the memories while busy
        else begin
            fail_count++;
            $error("host write issued while busy_o is high");
        end

endmodule

/* tb/pwo_tb.sv */
// Run from the project root; reads tb/pwo_tests.txt and assumes coef_count of 256
`timescale 1ns/1ps

module pwo_tb;

    import pwo_pkg::*;

    localparam int     coef_count = 256;
    localparam int     words      = coef_count / 4;
    localparam int     aw         = $clog2(words);
    localparam int     timeout    = words + 20;
    localparam longint q          = 8380417;

    logic              clk;
    logic              rst_n_i;
    logic              zeroize_i;
    logic              start_i;
    pwo_mode_e         mode_i;
    logic              accumulate_i;
    host_wr_t          host_wr_i;
    logic              host_rd_en_i;
    logic [aw-1:0]     host_rd_addr_i;
    logic [95:0]       host_rd_data_o;
    logic              busy_o;
    logic              done_o;

    logic [31:0]       lfsr_state;
    logic [23:0]       a_m [words*4];   // Models, index word*4 + lane
    logic [23:0]       b_m [words*4];
    logic [23:0]       c_m [words*4];
    logic [23:0]       e_m [words*4];
    int                errors;
    int                test_errs;
    int                tests;
    int                failed;
    logic              aborted;

    always #50 clk = ~clk;

    pwo_top #(.coef_count(coef_count)) i_dut (
        .clk(clk), .rst_n_i(rst_n_i), .zeroize_i(zeroize_i), .start_i(start_i),
        .mode_i(mode_i), .accumulate_i(accumulate_i), .host_wr_i(host_wr_i),
        .host_rd_en_i(host_rd_en_i), .host_rd_addr_i(host_rd_addr_i),
        .host_rd_data_o(host_rd_data_o), .busy_o(busy_o), .done_o(done_o)
    );

    bind pwo_top pwo_assertions i_assert (
        .clk(clk), .rst_n_i(rst_n_i), .busy_i(busy_o), .done_i(done_o), .host_wr_i(host_wr_i)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // 24 fresh bits, then brought below q
    function automatic logic [23:0] rand_coef();
        logic [23:0] bits;
        for (int i = 0; i < 24; i++) begin
            bits       = {bits[22:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return 24'(bits % q);
    endfunction

    function automatic logic [23:0] ref_op(input int mode, input logic acc,
                                           input longint a, input longint b, input longint c);
        longint r;
        case (mode)
            0:       r = acc ? (a * b + c) % q : (a * b) % q;
            1:       r = (a + b) % q;
            default: r = (a + q - b) % q;
        endcase
        return 24'(r);
    endfunction

    task automatic write_word(input mem_sel_e sel, input int addr, input logic [95:0] data);
        host_wr_i.sel     = sel;
        host_wr_i.wr.addr = 8'(addr);
        host_wr_i.wr.data = data;
        host_wr_i.wr.en   = 1'b1;
        @(posedge clk);
        #5;
        host_wr_i.wr.en = 1'b0;
    endtask

    task automatic read_word(input int addr, output logic [95:0] data);
        host_rd_addr_i = aw'(addr);
        host_rd_en_i   = 1'b1;
        @(posedge clk);
        #5;
        host_rd_en_i = 1'b0;
        data         = host_rd_data_o;   // Registered read, settled by now
    endtask

    task automatic fill_random();
        for (int i = 0; i < words * 4; i++) begin
            a_m[i] = rand_coef();
            b_m[i] = rand_coef();
            c_m[i] = rand_coef();
        end
    endtask

    task automatic load_memories();
        logic [95:0] wa;
        logic [95:0] wb;
        logic [95:0] wc;
        for (int w = 0; w < words; w++) begin
            for (int l = 0; l < 4; l++) begin
                wa[l*24 +: 24] = a_m[w*4+l];
                wb[l*24 +: 24] = b_m[w*4+l];
                wc[l*24 +: 24] = c_m[w*4+l];
            end
            write_word(mem_a, w, wa);
            write_word(mem_b, w, wb);
            write_word(mem_c, w, wc);
        end
    endtask

    // Start one operation and time it against the expected latency
    task automatic run_op(input int mode, input logic acc);
        int cycles;
        mode_i       = pwo_mode_e'(mode);
        accumulate_i = acc;
        start_i      = 1'b1;
        @(posedge clk);
        #5;
        start_i = 1'b0;
        cycles  = 1;
        while (!done_o && cycles < timeout) begin
            if (busy_o !== 1'b1) begin
                $display("ERR %0t busy_o got %b expected 1", $time, busy_o);
                test_errs++;
            end
            @(posedge clk);
            #5;
            cycles++;
        end
        if (!done_o) begin
            $display("Timed out after %0d cycles waiting for done_o", cycles);
            test_errs++;
            aborted = 1'b1;
        end else begin
            if (cycles != words + 5) begin
                $display("ERR %0t done_o latency got %0d expected %0d", $time, cycles, words + 5);
                test_errs++;
            end
            if (busy_o !== 1'b0) begin
                $display("ERR %0t busy_o got %b expected 0", $time, busy_o);
                test_errs++;
            end
        end
    endtask

    task automatic check_c();
        logic [95:0] got;
        for (int w = 0; w < words; w++) begin
            read_word(w, got);
            for (int l = 0; l < 4; l++) begin
                if (got[l*24 +: 24] !== e_m[w*4+l]) begin
                    $display("ERR %0t host_rd_data_o word %0d lane %0d got %h expected %h",
                             $time, w, l, got[l*24 +: 24], e_m[w*4+l]);
                    test_errs++;
                end
            end
        end
    endtask

    task automatic run_test_line(input logic [8*256-1:0] line, input logic [63:0] kind);
        int          mode;
        int          acc;
        int          n;
        logic [63:0] tag;
        logic [23:0] v [16];
        string       label;
        test_errs = 0;
        mode      = 0;
        acc       = 0;
        fill_random();
        if (kind == "dir") begin
            label = "directed";
            n = $sscanf(line, "%s %d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        tag, mode, acc, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                        v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15]);
            for (int l = 0; l < 4; l++) begin
                a_m[l] = v[l];   // Word 0 overridden
                b_m[l] = v[4+l];
                c_m[l] = v[8+l];
            end
        end else begin
            label = (kind == "zero") ? "zeroize" : "lfsr";
            n = $sscanf(line, "%s %d %d", tag, mode, acc);
        end
        if ((kind == "dir" && n != 19) || (kind != "dir" && n != 3)) begin
            $display("Malformed line in the tests file, %0d fields read", n);
            test_errs++;
        end
        load_memories();
        if (kind == "zero") begin
            zeroize_i = 1'b1;
            @(posedge clk);
            #5;
            zeroize_i = 1'b0;
            for (int i = 0; i < words * 4; i++) begin
                a_m[i] = '0;
                b_m[i] = '0;
                c_m[i] = '0;
                e_m[i] = '0;
            end
            check_c();   // Cleared C reads back as zero
        end
        for (int i = 0; i < words * 4; i++) begin
            e_m[i] = ref_op(mode, acc[0], a_m[i], b_m[i], c_m[i]);
        end
        if (kind == "dir") begin
            for (int l = 0; l < 4; l++) begin
                if (e_m[l] !== v[12+l]) begin
                    $display("Tests file expects %h in lane %0d, model computes %h",
                             v[12+l], l, e_m[l]);
                    test_errs++;
                end
                e_m[l] = v[12+l];
            end
        end
        run_op(mode, acc[0]);
        if (!aborted) begin
            check_c();
        end
        tests++;
        if (test_errs != 0) begin
            failed++;
        end
        errors += test_errs;
        $display("Test %0d %s mode %0d acc %0d: %s (%0d errors)", tests, label, mode, acc,
                 (test_errs == 0) ? "ok" : "mismatch", test_errs);
    endtask

    initial begin
        int               fd;
        int               n;
        logic [8*256-1:0] line;
        logic [63:0]      kind;
        clk            = 1'b0;
        rst_n_i        = 1'b0;
        zeroize_i      = 1'b0;
        start_i        = 1'b0;
        mode_i         = pwm;
        accumulate_i   = 1'b0;
        host_wr_i      = '0;
        host_rd_en_i   = 1'b0;
        host_rd_addr_i = '0;
        lfsr_state     = 32'hde20_0b23;
        errors         = 0;
        tests          = 0;
        failed         = 0;
        aborted        = 1'b0;
        repeat (3) @(posedge clk);
        #5;
        rst_n_i = 1'b1;
        fd = $fopen("tb/pwo_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open tb/pwo_tests.txt");
            errors++;
        end else begin
            while (!aborted && $fgets(line, fd) != 0) begin
                kind = '0;
                n    = $sscanf(line, "%s", kind);
                if (n == 1 && kind != "#") begin   // Skip comments and blank lines
                    if (kind == "dir" || kind == "lfsr" || kind == "zero") begin
                        run_test_line(line, kind);
                    end else begin
                        $display("Unknown test kind in the tests file");
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
        errors += i_dut.i_assert.fail_count;
        $display("Summary: %0d tests run, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0 && tests > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
design/pwo_pkg.sv
design/coef_ram.sv
design/mod_arith_lane.sv
design/pwo_ctrl.sv
design/pwo_top.sv
tb/pwo_assertions.sv
tb/pwo_tb.sv

/* tb/pwo_tests.txt */
# kind mode acc, then for dir: A0..A3 B0..B3 C0..C3 expected C0..C3 in hex, lane 0 first
# mode 0 multiply, 1 add, 2 subtract; lfsr fills all words, dir overrides word 0
dir 0 0 7fe000 0 2 123456 7fe000 abcde 3ff001 1 0 0 0 0 1 0 1 123456
dir 0 1 7fe000 2 0 3 7fe000 3ff001 5 4 7fe000 7fe000 7 10 0 0 7 1c
dir 1 0 7fe000 400000 1 0 1 400000 2 0 0 0 0 0 0 1fff 3 0
dir 2 0 0 5 1 7fe000 1 3 7fe000 0 0 0 0 0 7fe000 2 2 7fe000
lfsr 0 0
lfsr 0 1
lfsr 1 0
lfsr 2 0
lfsr 1 1
lfsr 2 1
zero 0 0
zero 0 1
